// File: files.f
battle_pkg.sv
battle_control.sv
sprite_plotter.sv
frame_timer.sv
hp_tracker.sv
battle_top.sv
battle_properties.sv
tb_battle.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, status follows the result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -j 0 --top-module tb_battle -f files.f \
		-o sim_battle \
	&& ./obj_dir/sim_battle +verilator+error+limit+1000 | tee /dev/stderr \
		| grep -q "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

// File: tb_battle.sv
`timescale 1ns/10ps
`default_nettype none

module tb_battle;

	logic clock;
	logic reset;
	logic quick_attack;
	logic plot;
	battle_pkg::pixel_t pixel;
	logic game_over;

	logic [2:0] img [240][320]; // what the DUT has plotted
	logic [2:0] exp_img [240][320];
	int pixel_count;
	int mismatch_count = 0;
	int other_count = 0;
	int hp_model;
	logic [31:0] rng;

	battle_top UUT (
		.clock(clock),
		.reset(reset),
		.quick_attack(quick_attack),
		.plot(plot),
		.pixel(pixel),
		.game_over(game_over)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// pixel scoreboard
	always @(posedge clock)
	begin
		if (!reset)
		begin
			pixel_count <= 0;
			for (int y = 0; y < 240; y++)
				for (int x = 0; x < 320; x++)
					img[y][x] <= '0;
		end
		else if (plot)
		begin
			pixel_count <= pixel_count + 1;
			if (pixel.x < 9'd320 && pixel.y < 8'd240)
				img[pixel.y][pixel.x] <= pixel.colour;
		end
	end

	function automatic logic [31:0] xorshift(logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int area(battle_pkg::rect_t r);
		return int'(r.width) * int'(r.height);
	endfunction

	task automatic paint_rect(battle_pkg::rect_t r, int offset, battle_pkg::colour_t colour);
		for (int yy = 0; yy < int'(r.height); yy++)
			for (int xx = 0; xx < int'(r.width); xx++)
				exp_img[int'(r.y) + yy][int'(r.x) + offset + xx] = colour;
	endtask

	// sprite walk, return home, then one white bar column per hp point
	task automatic predict_attack(output int plotted);
		battle_pkg::rect_t player;
		battle_pkg::rect_t column;
		int dmg;
		player = battle_pkg::element_rect(battle_pkg::EL_PLAYER);
		column = battle_pkg::element_rect(battle_pkg::EL_HP_COLUMN);
		for (int f = 0; f < battle_pkg::ATTACK_FRAMES; f++)
		begin
			paint_rect(player, f * battle_pkg::ATTACK_STEP, battle_pkg::ERASE_COLOUR);
			paint_rect(player, (f + 1) * battle_pkg::ATTACK_STEP, player.colour);
		end
		paint_rect(player, battle_pkg::ATTACK_FRAMES * battle_pkg::ATTACK_STEP,
			battle_pkg::ERASE_COLOUR);
		paint_rect(player, 0, player.colour);
		dmg = (hp_model < battle_pkg::ATTACK_DAMAGE) ? hp_model : battle_pkg::ATTACK_DAMAGE;
		for (int d = 0; d < dmg; d++)
		begin
			hp_model--;
			paint_rect(column, hp_model, column.colour); // rightmost live column
		end
		plotted = (2 * battle_pkg::ATTACK_FRAMES + 2) * area(player) + dmg * area(column);
	endtask

	task automatic press_button();
		@(posedge clock);
		quick_attack <= 1'b1;
		@(posedge clock);
		quick_attack <= 1'b0;
	endtask

	task automatic wait_pixels(int target);
		int cycles;
		cycles = 0;
		while (pixel_count < target && cycles < 5000)
		begin
			@(posedge clock);
			cycles++;
		end
		if (pixel_count < target)
		begin
			other_count++;
			$display("timeout at %0t: only %0d of %0d pixels were plotted",
				$time, pixel_count, target);
		end
	endtask

	task automatic check_quiet(int cycles, int target);
		repeat (cycles) @(posedge clock);
		assert (pixel_count == target)
		else
		begin
			mismatch_count++;
			$display("mismatch at %0t: pixel_count is %0d, expected %0d",
				$time, pixel_count, target);
		end
	endtask

	task automatic compare_image(string phase);
		int bad;
		bad = 0;
		for (int y = 0; y < 240; y++)
			for (int x = 0; x < 320; x++)
				assert (img[y][x] == exp_img[y][x])
				else
				begin
					bad++;
					$display("mismatch at %0t: img[%0d][%0d] after %s is %0d, expected %0d",
						$time, y, x, phase, img[y][x], exp_img[y][x]);
				end
		mismatch_count += bad;
	endtask

	initial
	begin
		battle_pkg::rect_t r;
		int expected;
		int plotted;
		int total;
		reset <= 1'b0;
		quick_attack <= 1'b0;
		rng = 32'd25165;
		hp_model = battle_pkg::HP_MAX;
		expected = 0;
		for (int y = 0; y < 240; y++)
			for (int x = 0; x < 320; x++)
				exp_img[y][x] = '0;
		for (int e = 0; e < 7; e++) // later draws win in scene order
		begin
			r = battle_pkg::element_rect(battle_pkg::element_e'(e));
			paint_rect(r, 0, r.colour);
			expected += area(r);
		end
		repeat (3) @(posedge clock);
		reset <= 1'b1;

		wait_pixels(expected);
		check_quiet(100, expected);
		compare_image("scene");

		for (int a = 0; a < (battle_pkg::HP_MAX + battle_pkg::ATTACK_DAMAGE - 1)
			/ battle_pkg::ATTACK_DAMAGE; a++)
		begin
			rng = xorshift(rng);
			repeat (int'(rng[3:0]) + 1) @(posedge clock);
			press_button();
			predict_attack(plotted);
			expected += plotted;
			wait_pixels(expected);
			check_quiet(60, expected);
			compare_image("attack");
			assert (game_over == (hp_model == 0))
			else
			begin
				mismatch_count++;
				$display("mismatch at %0t: game_over is %b, expected %b",
					$time, game_over, hp_model == 0);
			end
		end

		press_button(); // nothing may move once the game is over
		check_quiet(200, expected);
		compare_image("press after game over");

		total = mismatch_count + other_count + UUT.u_properties.fail_count;
		$display("errors: %0d mismatches, %0d other failures, %0d property failures",
			mismatch_count, other_count, UUT.u_properties.fail_count);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: battle_properties.sv
`timescale 1ns/10ps
`default_nettype none

module battle_properties (
	input wire clock,
	input wire reset,
	input wire plot,
	input wire battle_pkg::pixel_t pixel,
	input wire game_over
);

	int fail_count = 0;

	// nothing plotted in the two cycles after any reset cycle
	plot_low_after_reset: assert property (@(posedge clock)
		!$past(reset) || !$past(reset, 2) |-> !plot)
	else
	begin
		fail_count++;
		$error("plot high within two cycles after reset");
	end

	pixel_on_screen: assert property (@(posedge clock) disable iff (!reset)
		plot |-> (pixel.x < 9'd320) && (pixel.y < 8'd240))
	else
	begin
		fail_count++;
		$error("plotted pixel lies off screen");
	end

	game_over_sticky: assert property (@(posedge clock) disable iff (!reset)
		game_over |=> game_over)
	else
	begin
		fail_count++;
		$error("game_over fell while out of reset");
	end

endmodule

bind battle_top battle_properties u_properties (
	.clock(clock),
	.reset(reset),
	.plot(plot),
	.pixel(pixel),
	.game_over(game_over)
);

`default_nettype wire

// File: battle_top.sv
`timescale 1ns/10ps
`default_nettype none

module battle_top (
	input wire clock,
	input wire reset,
	input wire quick_attack,
	output logic plot,
	output battle_pkg::pixel_t pixel,
	output logic game_over
);

	logic draw_start;
	battle_pkg::element_e draw_element;
	logic draw_erase;
	battle_pkg::coord_x_t draw_offset;
	logic draw_done;
	logic frame_enable;
	logic frame_done;
	logic hit;
	logic hp_step;
	battle_pkg::hp_t hp;
	logic damage_left;

	battle_control u_control (.*);

	sprite_plotter u_plotter (.*);

	frame_timer u_timer (.*);

	hp_tracker u_hp (.*);

endmodule

`default_nettype wire

// File: hp_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module hp_tracker (
	input wire clock,
	input wire reset,
	input wire hit,
	input wire hp_step,
	output battle_pkg::hp_t hp,
	output logic damage_left,
	output logic game_over
);

	battle_pkg::hp_t pending;
	battle_pkg::hp_t damage;

	// never more damage than hp left
	assign damage = (hp < battle_pkg::hp_t'(battle_pkg::ATTACK_DAMAGE))
		? hp : battle_pkg::hp_t'(battle_pkg::ATTACK_DAMAGE);
	assign damage_left = pending != '0;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			hp <= battle_pkg::hp_t'(battle_pkg::HP_MAX);
			pending <= '0;
			game_over <= 1'b0;
		end
		else
		begin
			if (hit)
				pending <= damage;
			else if (hp_step && damage_left)
			begin
				hp <= hp - 1'b1;
				pending <= pending - 1'b1;
			end
			if (hp == '0)
				game_over <= 1'b1; // sticky
		end
	end

endmodule

`default_nettype wire

// File: frame_timer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_timer (
	input wire clock,
	input wire reset,
	input wire frame_enable,
	output logic frame_done
);

	battle_pkg::tick_count_t prescale;
	battle_pkg::frame_tick_t ticks;
	logic tick_end;
	logic frame_end;

	assign tick_end = prescale == battle_pkg::tick_count_t'(battle_pkg::TICK_CYCLES - 1);
	assign frame_end = tick_end
		&& (ticks == battle_pkg::frame_tick_t'(battle_pkg::FRAME_TICKS - 1));

	always_ff @(posedge clock)
	begin
		if (!reset || !frame_enable)
		begin
			prescale <= '0;
			ticks <= '0;
		end
		else
		begin
			prescale <= tick_end ? '0 : prescale + 1'b1;
			if (tick_end)
				ticks <= frame_end ? '0 : ticks + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
			frame_done <= 1'b0;
		else
			frame_done <= frame_enable && frame_end; // one cycle per frame
	end

endmodule

`default_nettype wire

// File: sprite_plotter.sv
`timescale 1ns/10ps
`default_nettype none

module sprite_plotter (
	input wire clock,
	input wire reset,
	input wire draw_start,
	input wire battle_pkg::element_e draw_element,
	input wire draw_erase,
	input wire battle_pkg::coord_x_t draw_offset,
	output logic plot,
	output battle_pkg::pixel_t pixel,
	output logic draw_done
);

	battle_pkg::rect_t rect_q;
	battle_pkg::coord_x_t offset_q;
	logic erase_q;
	battle_pkg::coord_x_t col; // column within the rect
	battle_pkg::coord_y_t row;

	battle_pkg::rect_t src_rect;
	battle_pkg::coord_x_t src_offset;
	logic src_erase;
	battle_pkg::coord_x_t next_col;
	battle_pkg::coord_y_t next_row;
	logic next_last;
	logic emit;

	// first pixel comes straight from the lookup so the scan starts one cycle after start
	always_comb
	begin
		src_rect = draw_start ? battle_pkg::element_rect(draw_element) : rect_q;
		src_offset = draw_start ? draw_offset : offset_q;
		src_erase = draw_start ? draw_erase : erase_q;
		emit = draw_start || (plot && !draw_done);
		if (draw_start)
		begin
			next_col = '0;
			next_row = '0;
		end
		else if (col == rect_q.width - 1'b1)
		begin
			next_col = '0;
			next_row = row + 1'b1;
		end
		else
		begin
			next_col = col + 1'b1;
			next_row = row;
		end
		next_last = (next_col == src_rect.width - 1'b1) && (next_row == src_rect.height - 1'b1);
	end

	always_ff @(posedge clock)
	begin
		if (draw_start)
		begin
			rect_q <= src_rect;
			offset_q <= src_offset;
			erase_q <= src_erase;
		end
		if (emit)
		begin
			col <= next_col;
			row <= next_row;
			pixel.x <= src_rect.x + src_offset + next_col;
			pixel.y <= src_rect.y + next_row;
			pixel.colour <= src_erase ? battle_pkg::ERASE_COLOUR : src_rect.colour;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			plot <= 1'b0;
			draw_done <= 1'b0;
		end
		else
		begin
			plot <= emit;
			draw_done <= emit && next_last;
		end
	end

endmodule

`default_nettype wire

// File: battle_control.sv
`timescale 1ns/10ps
`default_nettype none

module battle_control (
	input wire clock,
	input wire reset,
	input wire quick_attack,
	input wire draw_done,
	input wire frame_done,
	input wire damage_left,
	input wire game_over,
	input wire battle_pkg::hp_t hp,
	output logic draw_start,
	output battle_pkg::element_e draw_element,
	output logic draw_erase,
	output battle_pkg::coord_x_t draw_offset,
	output logic frame_enable,
	output logic hit,
	output logic hp_step
);

	battle_pkg::state_e state;
	battle_pkg::state_e next_state;
	battle_pkg::attack_count_t frame_count;
	logic starts_draw;

	always_comb
	begin
		next_state = state;
		case (state)
			battle_pkg::S_RESET: next_state = battle_pkg::S_DRAW_PLAYER;
			battle_pkg::S_DRAW_PLAYER:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_ENEMY_HP;
			battle_pkg::S_DRAW_ENEMY_HP:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_PLAYER_HP;
			battle_pkg::S_DRAW_PLAYER_HP:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_RIVAL;
			battle_pkg::S_DRAW_RIVAL:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_TRAINER;
			battle_pkg::S_DRAW_TRAINER:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_MENU;
			battle_pkg::S_DRAW_MENU:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_ENEMY;
			battle_pkg::S_DRAW_ENEMY:
				if (draw_done)
					next_state = battle_pkg::S_IDLE;
			battle_pkg::S_IDLE:
				if (game_over)
					next_state = battle_pkg::S_GAME_OVER;
				else if (quick_attack)
					next_state = battle_pkg::S_ERASE_PLAYER;
			battle_pkg::S_ERASE_PLAYER:
				if (draw_done)
					next_state = battle_pkg::S_MOVE;
			battle_pkg::S_MOVE: next_state = battle_pkg::S_DRAW_ATTACK;
			battle_pkg::S_DRAW_ATTACK:
				if (draw_done)
					next_state = battle_pkg::S_WAIT_FRAME;
			battle_pkg::S_WAIT_FRAME:
				if (frame_done)
				begin
					if (frame_count == battle_pkg::attack_count_t'(battle_pkg::ATTACK_FRAMES))
						next_state = battle_pkg::S_ERASE_LAST;
					else
						next_state = battle_pkg::S_ERASE_PLAYER;
				end
			battle_pkg::S_ERASE_LAST:
				if (draw_done)
					next_state = battle_pkg::S_DRAW_HOME;
			battle_pkg::S_DRAW_HOME:
				if (draw_done)
					next_state = battle_pkg::S_HIT;
			battle_pkg::S_HIT: next_state = battle_pkg::S_NEXT_HP;
			battle_pkg::S_NEXT_HP:
				if (damage_left)
					next_state = battle_pkg::S_ERASE_HP;
				else if (game_over)
					next_state = battle_pkg::S_GAME_OVER;
				else if (hp != '0)
					next_state = battle_pkg::S_IDLE; // at zero hp wait for game_over
			battle_pkg::S_ERASE_HP:
				if (draw_done)
					next_state = battle_pkg::S_NEXT_HP;
			battle_pkg::S_GAME_OVER: next_state = battle_pkg::S_GAME_OVER;
		endcase
		starts_draw = (next_state != state) && (next_state inside {
			battle_pkg::S_DRAW_PLAYER, battle_pkg::S_DRAW_ENEMY_HP, battle_pkg::S_DRAW_PLAYER_HP,
			battle_pkg::S_DRAW_RIVAL, battle_pkg::S_DRAW_TRAINER, battle_pkg::S_DRAW_MENU,
			battle_pkg::S_DRAW_ENEMY, battle_pkg::S_ERASE_PLAYER, battle_pkg::S_DRAW_ATTACK,
			battle_pkg::S_ERASE_LAST, battle_pkg::S_DRAW_HOME, battle_pkg::S_ERASE_HP});
	end

	always_comb
	begin
		case (state)
			battle_pkg::S_DRAW_ENEMY_HP: draw_element = battle_pkg::EL_ENEMY_HP;
			battle_pkg::S_DRAW_PLAYER_HP: draw_element = battle_pkg::EL_PLAYER_HP;
			battle_pkg::S_DRAW_RIVAL: draw_element = battle_pkg::EL_RIVAL;
			battle_pkg::S_DRAW_TRAINER: draw_element = battle_pkg::EL_TRAINER;
			battle_pkg::S_DRAW_MENU: draw_element = battle_pkg::EL_MENU;
			battle_pkg::S_DRAW_ENEMY: draw_element = battle_pkg::EL_ENEMY;
			battle_pkg::S_ERASE_HP: draw_element = battle_pkg::EL_HP_COLUMN;
			default: draw_element = battle_pkg::EL_PLAYER; // scene start and attack frames
		endcase
	end

	assign draw_erase = (state == battle_pkg::S_ERASE_PLAYER) || (state == battle_pkg::S_ERASE_LAST);
	assign frame_enable = state == battle_pkg::S_WAIT_FRAME;
	assign hit = state == battle_pkg::S_HIT;
	assign hp_step = (state == battle_pkg::S_ERASE_HP) && draw_done;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			state <= battle_pkg::S_RESET;
			draw_start <= 1'b0;
			draw_offset <= '0;
			frame_count <= '0;
		end
		else
		begin
			state <= next_state;
			draw_start <= starts_draw;
			case (state)
				battle_pkg::S_IDLE:
				begin
					draw_offset <= '0;
					frame_count <= '0;
				end
				battle_pkg::S_MOVE:
				begin
					draw_offset <= draw_offset + battle_pkg::coord_x_t'(battle_pkg::ATTACK_STEP);
					frame_count <= frame_count + 1'b1;
				end
				battle_pkg::S_ERASE_LAST:
					if (draw_done)
						draw_offset <= '0; // back home
				battle_pkg::S_NEXT_HP:
					draw_offset <= battle_pkg::coord_x_t'(hp) - 1'b1; // rightmost live column
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: battle_pkg.sv
`default_nettype none

package battle_pkg;

	localparam int X_BITS = 9;
	localparam int Y_BITS = 8;
	localparam int COLOUR_BITS = 3;

	typedef logic [X_BITS-1:0] coord_x_t;
	typedef logic [Y_BITS-1:0] coord_y_t;
	typedef logic [COLOUR_BITS-1:0] colour_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		coord_x_t width;
		coord_y_t height;
		colour_t colour;
	} rect_t;

	typedef enum logic [2:0] {
		EL_PLAYER, EL_ENEMY_HP, EL_PLAYER_HP, EL_RIVAL,
		EL_TRAINER, EL_MENU, EL_ENEMY, EL_HP_COLUMN
	} element_e;

	typedef enum logic [4:0] {
		S_RESET,
		S_DRAW_PLAYER, S_DRAW_ENEMY_HP, S_DRAW_PLAYER_HP, S_DRAW_RIVAL,
		S_DRAW_TRAINER, S_DRAW_MENU, S_DRAW_ENEMY,
		S_IDLE,
		S_ERASE_PLAYER, S_MOVE, S_DRAW_ATTACK, S_WAIT_FRAME, S_ERASE_LAST, S_DRAW_HOME,
		S_HIT, S_ERASE_HP, S_NEXT_HP,
		S_GAME_OVER
	} state_e;

	localparam colour_t ERASE_COLOUR = 3'd7; // white
	localparam int HP_MAX = 10; // one bar column per point
	localparam int ATTACK_DAMAGE = 3;
	localparam int ATTACK_FRAMES = 3;
	localparam int ATTACK_STEP = 4;
	localparam int TICK_CYCLES = 8;
	localparam int FRAME_TICKS = 4;

	typedef logic [$clog2(HP_MAX + 1) - 1:0] hp_t;
	typedef logic [$clog2(ATTACK_FRAMES + 1) - 1:0] attack_count_t;
	typedef logic [$clog2(TICK_CYCLES) - 1:0] tick_count_t;
	typedef logic [$clog2(FRAME_TICKS) - 1:0] frame_tick_t;

	// scene geometry as plain rectangles
	function automatic rect_t element_rect(element_e element);
		rect_t rect;
		case (element)
			EL_PLAYER: rect = '{x: 9'd40, y: 8'd120, width: 9'd12, height: 8'd10, colour: 3'd2};
			EL_ENEMY_HP: rect = '{x: 9'd20, y: 8'd20, width: 9'd10, height: 8'd4, colour: 3'd4};
			EL_PLAYER_HP: rect = '{x: 9'd200, y: 8'd150, width: 9'd10, height: 8'd4, colour: 3'd4};
			EL_RIVAL: rect = '{x: 9'd250, y: 8'd40, width: 9'd16, height: 8'd12, colour: 3'd5};
			EL_TRAINER: rect = '{x: 9'd5, y: 8'd200, width: 9'd12, height: 8'd16, colour: 3'd1};
			EL_MENU: rect = '{x: 9'd130, y: 8'd200, width: 9'd40, height: 8'd20, colour: 3'd6};
			EL_ENEMY: rect = '{x: 9'd220, y: 8'd40, width: 9'd14, height: 8'd12, colour: 3'd3};
			// leftmost enemy bar column that the caller shifts
			EL_HP_COLUMN:
				rect = '{x: 9'd20, y: 8'd20, width: 9'd1, height: 8'd4, colour: ERASE_COLOUR};
		endcase
		return rect;
	endfunction

endpackage

`default_nettype wire
